// ==== tests/shim_tests.txt ====
# c0_hdr c0_data c0_stb(wr rd cg ug) c1_hdr c1_stb(wr intr) tx_wr tx_type tx_addr tx_mdata tx_rd
# next cycle: c0_valid(rd umsg mmio_wr mmio_rd) c0_hdr c0_data c1_native(1 wr 2 intr) alm_full
40123 0011223344556677 4 00000 0 1 1 2ab00001000 c010 1 8 40123 0011223344556677 0 0
f0005 8899aabbccddeeff 1 00000 0 1 2 1ff00002040 4011 0 4 f0005 8899aabbccddeeff 0 0
00020 00000000cafe0001 2 00000 0 1 1 00000003080 0012 0 2 10020 00000000cafe0001 0 0
00024 00000000beef0002 2 00000 0 1 2 3ff000040c0 8013 1 2 10024 cafe0001beef0002 0 0
00ff0 0000000000000abc 2 00000 0 1 1 00000005100 0014 0 1 10abc beef000200000abc 0 0
00000 0000000000000000 0 00000 0 1 2 12300006140 c015 1 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 1 00000007180 0016 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 2 2aa000081c0 4017 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 1 00000009200 0018 1 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 2 0010000a240 8019 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 1 0000000b280 001a 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 1 2 3010000c2c0 c01b 0 0 00000 0000000000000000 0 1
00000 0000000000000000 0 00000 0 1 5 0000000d300 001c 0 0 00000 0000000000000000 0 1
10101 0000000000000000 8 00000 0 0 0 00000000000 0000 0 0 00000 0000000000000000 0 1
10102 0000000000000000 8 10201 2 0 0 00000000000 0000 0 0 00000 0000000000000000 1 1
00000 0000000000000000 0 10202 2 0 0 00000000000 0000 0 0 00000 0000000000000000 1 0
00000 0000000000000000 0 80000 1 0 0 00000000000 0000 0 0 00000 0000000000000000 2 0
00000 0000000000000000 0 00000 0 0 0 00000000000 0000 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 0 0 00000000000 0000 0 0 00000 0000000000000000 0 0
00000 0000000000000000 0 00000 0 0 8 0000000e340 001d 0 0 00000 0000000000000000 0 0

// ==== list.f ====
+incdir+design
design/shim_pkg.sv
design/csr_rx_decoder.sv
design/wr_rsp_queue.sv
design/c1_rsp_arbiter.sv
design/wr_credit_counter.sv
design/legacy_link_shim.sv
tests/shim_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the shim testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module shim_tb -o shim_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
obj_dir/shim_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== tests/shim_tb.sv ====
/*
 * Testbench for the legacy link shim. Replays tests/shim_tests.txt one line per
 * cycle and checks requests in the same cycle and responses one cycle later.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module shim_tb;

    logic                              clk;
    logic                              reset;
    logic                              c0_tx_rd_valid;
    logic [`SHIM_AFU_ADDR_WIDTH-1:0]   c0_tx_addr;
    logic [`SHIM_AFU_MDATA_WIDTH-1:0]  c0_tx_mdata;
    logic                              c1_tx_wr_valid;
    logic                              c1_tx_intr_valid;
    shim_pkg::req_type_e               c1_tx_req_type;
    logic [`SHIM_AFU_ADDR_WIDTH-1:0]   c1_tx_addr;
    logic [`SHIM_AFU_MDATA_WIDTH-1:0]  c1_tx_mdata;
    logic [`SHIM_DATA_WIDTH-1:0]       c1_tx_data;
    logic                              c0_tx_alm_full;
    logic                              c1_tx_alm_full;
    shim_pkg::rx_hdr_u                 c0_rx_hdr;
    logic [`SHIM_DATA_WIDTH-1:0]       c0_rx_data;
    logic                              c0_rx_wr_valid;
    logic                              c0_rx_rd_valid;
    logic                              c0_rx_umsg_valid;
    logic                              c0_rx_mmio_wr_valid;
    logic                              c0_rx_mmio_rd_valid;
    shim_pkg::rx_hdr_u                 c1_rx_hdr;
    logic                              c1_rx_wr_valid;
    logic                              c1_rx_intr_valid;
    logic                              link_c0_tx_rd_valid;
    logic [`SHIM_ADDR_WIDTH-1:0]       link_c0_tx_addr;
    logic [`SHIM_MDATA_WIDTH-1:0]      link_c0_tx_mdata;
    logic                              link_c1_tx_wr_valid;
    logic                              link_c1_tx_intr_valid;
    shim_pkg::req_type_e               link_c1_tx_req_type;
    logic [`SHIM_ADDR_WIDTH-1:0]       link_c1_tx_addr;
    logic [`SHIM_MDATA_WIDTH-1:0]      link_c1_tx_mdata;
    logic [`SHIM_DATA_WIDTH-1:0]       link_c1_tx_data;
    logic                              link_c0_tx_alm_full;
    logic                              link_c1_tx_alm_full;
    shim_pkg::rx_hdr_u                 link_c0_rx_hdr;
    logic [`SHIM_DATA_WIDTH-1:0]       link_c0_rx_data;
    logic                              link_c0_rx_wr_valid;
    logic                              link_c0_rx_rd_valid;
    logic                              link_c0_rx_cg_valid;
    logic                              link_c0_rx_ug_valid;
    shim_pkg::rx_hdr_u                 link_c1_rx_hdr;
    logic                              link_c1_rx_wr_valid;
    logic                              link_c1_rx_intr_valid;

    // Fields of the current data line
    logic [19:0] c0_hdr_v, c1_hdr_v, exp_hdr_v;
    logic [63:0] c0_data_v, exp_data_v, tx_data_v;
    logic [3:0]  c0_stb_v, tx_type_v, exp_c0_v;
    logic [1:0]  c1_stb_v, exp_c1_v;
    logic        tx_wr_v, tx_rd_v, exp_alm_v;
    logic [41:0] tx_addr_v;
    logic [15:0] tx_mdata_v;
    logic [1:0]  link_alm_v;   // Link almost-full levels (c0 c1)

    // Expectations of the previous line checked this cycle
    logic [19:0] prev_exp_hdr, prev_c1_hdr;
    logic [63:0] prev_exp_data;
    logic [3:0]  prev_exp_c0;
    logic [1:0]  prev_exp_c1;
    logic        prev_exp_alm;
    bit          have_prev;

    logic [13:0] reloc_tags [$];   // Channel 0 write tags in arrival order
    string       lines [$];
    int          n_lines;
    int          seed;
    int          idx;

    legacy_link_shim DUT (.*);

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        fd = $fopen("tests/shim_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the test data file tests/shim_tests.txt");
            stop_run();
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")   // Skip comments and blanks
                lines.push_back(line);
        end
        $fclose(fd);
        n_lines = lines.size();
    endtask

    task automatic parse_line(input string line);
        int n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    c0_hdr_v, c0_data_v, c0_stb_v, c1_hdr_v, c1_stb_v, tx_wr_v,
                    tx_type_v, tx_addr_v, tx_mdata_v, tx_rd_v, exp_c0_v, exp_hdr_v,
                    exp_data_v, exp_c1_v, exp_alm_v);
        if (n != 15)
        begin
            $display("Malformed line in the test data file: %s", line);
            stop_run();
        end
    endtask

    task automatic clear_line();
        {c0_hdr_v, c0_data_v, c0_stb_v, c1_hdr_v, c1_stb_v, tx_wr_v} = '0;
        {tx_type_v, tx_addr_v, tx_mdata_v, tx_rd_v} = '0;
        {exp_c0_v, exp_hdr_v, exp_data_v, exp_c1_v, exp_alm_v} = '0;
        link_alm_v = '0;
    endtask

    // Called right after a rising edge
    task automatic drive_line();
        tx_data_v = {$random(seed), $random(seed)};
        link_c0_rx_hdr        <= c0_hdr_v;
        link_c0_rx_data       <= c0_data_v;
        link_c0_rx_wr_valid   <= c0_stb_v[3];
        link_c0_rx_rd_valid   <= c0_stb_v[2];
        link_c0_rx_cg_valid   <= c0_stb_v[1];
        link_c0_rx_ug_valid   <= c0_stb_v[0];
        link_c1_rx_hdr        <= c1_hdr_v;
        link_c1_rx_wr_valid   <= c1_stb_v[1];
        link_c1_rx_intr_valid <= c1_stb_v[0];
        link_c0_tx_alm_full   <= link_alm_v[1];
        link_c1_tx_alm_full   <= link_alm_v[0];
        c0_tx_rd_valid        <= tx_rd_v;
        c0_tx_addr            <= tx_addr_v;
        c0_tx_mdata           <= tx_mdata_v;
        c1_tx_wr_valid        <= tx_wr_v;
        c1_tx_intr_valid      <= (tx_type_v == 4'h8);   // Interrupt request
        c1_tx_req_type        <= shim_pkg::req_type_e'(tx_type_v);
        c1_tx_addr            <= tx_addr_v;
        c1_tx_mdata           <= tx_mdata_v;
        c1_tx_data            <= tx_data_v;
        if (c0_stb_v[3])
            reloc_tags.push_back(c0_hdr_v[13:0]);
    endtask

    // --------------------
    // Request mapping in the same cycle with low bits kept
    task automatic check_requests();
        check_value("link_c0_tx_rd_valid", 64'(tx_rd_v), 64'(link_c0_tx_rd_valid));
        check_value("link_c0_tx_addr", 64'(tx_addr_v[31:0]), 64'(link_c0_tx_addr));
        check_value("link_c0_tx_mdata", 64'(tx_mdata_v[13:0]), 64'(link_c0_tx_mdata));
        check_value("link_c1_tx_wr_valid", 64'(tx_wr_v), 64'(link_c1_tx_wr_valid));
        check_value("link_c1_tx_intr_valid", 64'(tx_type_v == 4'h8),
                    64'(link_c1_tx_intr_valid));
        check_value("link_c1_tx_req_type", 64'(tx_type_v), 64'(link_c1_tx_req_type));
        check_value("link_c1_tx_addr", 64'(tx_addr_v[31:0]), 64'(link_c1_tx_addr));
        check_value("link_c1_tx_mdata", 64'(tx_mdata_v[13:0]), 64'(link_c1_tx_mdata));
        check_value("link_c1_tx_data", tx_data_v, link_c1_tx_data);
        check_value("c0_tx_alm_full", 64'(link_alm_v[1]), 64'(c0_tx_alm_full));
    endtask

    // --------------------
    // Responses of the line before
    task automatic check_responses();
        check_value("c0_rx_wr_valid", 64'(0), 64'(c0_rx_wr_valid));
        check_value("c0_rx valid strobes", 64'(prev_exp_c0),
                    64'({c0_rx_rd_valid, c0_rx_umsg_valid, c0_rx_mmio_wr_valid,
                         c0_rx_mmio_rd_valid}));
        if (prev_exp_c0 != 4'h0)
        begin
            check_value("c0_rx_hdr", 64'(prev_exp_hdr), 64'(c0_rx_hdr));
            check_value("c0_rx_data", prev_exp_data, c0_rx_data);
        end
        check_value("c1_rx_intr_valid", 64'(prev_exp_c1 == 2'd2), 64'(c1_rx_intr_valid));
        if (prev_exp_c1 != 2'd0)
        begin
            // Native response keeps its fixed latency and header
            check_value("c1_rx_wr_valid", 64'(prev_exp_c1 == 2'd1), 64'(c1_rx_wr_valid));
            check_value("c1_rx_hdr", 64'(prev_c1_hdr), 64'(c1_rx_hdr));
        end
        else if (c1_rx_wr_valid)
        begin
            if (reloc_tags.size() == 0)
            begin
                $display("A write response appeared on channel 1 with no tag pending");
                stop_run();
            end
            check_value("c1_rx_hdr.rsp_type", 64'h1, 64'(c1_rx_hdr.rsp.rsp_type));
            check_value("c1_rx_hdr.mdata", 64'(reloc_tags.pop_front()),
                        64'(c1_rx_hdr.rsp.mdata));
        end
        check_value("c1_tx_alm_full", 64'(prev_exp_alm || link_alm_v[0]),
                    64'(c1_tx_alm_full));
    endtask

    task automatic save_expected();
        prev_exp_c0   = exp_c0_v;
        prev_exp_hdr  = exp_hdr_v;
        prev_exp_data = exp_data_v;
        prev_exp_c1   = exp_c1_v;
        prev_exp_alm  = exp_alm_v;
        prev_c1_hdr   = c1_hdr_v;
        have_prev     = 1'b1;
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        seed = 5415;
        n_lines = 0;
        have_prev = 1'b0;
        clear_line();
        drive_line();
        load_tests();
        if (n_lines == 0)
        begin
            $display("The test data file holds no stimulus lines");
            stop_run();
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (idx = 0; idx < n_lines; idx++)
        begin
            @(posedge clk);
            parse_line(lines[idx]);
            drive_line();
            @(negedge clk);   // Outputs settled by mid cycle
            check_requests();
            if (have_prev)
                check_responses();
            save_expected();
        end

        // One idle cycle collects the last line's responses
        @(posedge clk);
        clear_line();
        link_alm_v = 2'b11;   // Link back-pressure while the credit flag is low
        drive_line();
        @(negedge clk);
        check_requests();
        check_responses();

        if (reloc_tags.size() != 0)
        begin
            $display("%0d relocated write responses never reached channel 1",
                     reloc_tags.size());
            stop_run();
        end
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

    // Watchdog allows four clock periods per data line plus reset
    initial
    begin
        wait (n_lines > 0);
        #(n_lines * 20 * 4 + 10 * 20);
        $display("Timeout: the run did not finish in time");
        stop_run();
    end

endmodule

// ==== design/legacy_link_shim.sv ====
/*
 * Top of the shim between an accelerator and the older two-channel link.
 * Requests pass straight through; responses are registered and regrouped.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module legacy_link_shim
(
    input  logic                              clk,
    input  logic                              reset,

    // Accelerator requests
    input  logic                              c0_tx_rd_valid,
    input  logic [`SHIM_AFU_ADDR_WIDTH-1:0]   c0_tx_addr,
    input  logic [`SHIM_AFU_MDATA_WIDTH-1:0]  c0_tx_mdata,
    input  logic                              c1_tx_wr_valid,
    input  logic                              c1_tx_intr_valid,
    input  shim_pkg::req_type_e               c1_tx_req_type,
    input  logic [`SHIM_AFU_ADDR_WIDTH-1:0]   c1_tx_addr,
    input  logic [`SHIM_AFU_MDATA_WIDTH-1:0]  c1_tx_mdata,
    input  logic [`SHIM_DATA_WIDTH-1:0]       c1_tx_data,
    output logic                              c0_tx_alm_full,
    output logic                              c1_tx_alm_full,

    // Accelerator responses
    output shim_pkg::rx_hdr_u                 c0_rx_hdr,
    output logic [`SHIM_DATA_WIDTH-1:0]       c0_rx_data,
    output logic                              c0_rx_wr_valid,
    output logic                              c0_rx_rd_valid,
    output logic                              c0_rx_umsg_valid,
    output logic                              c0_rx_mmio_wr_valid,
    output logic                              c0_rx_mmio_rd_valid,
    output shim_pkg::rx_hdr_u                 c1_rx_hdr,
    output logic                              c1_rx_wr_valid,
    output logic                              c1_rx_intr_valid,

    // Link requests
    output logic                              link_c0_tx_rd_valid,
    output logic [`SHIM_ADDR_WIDTH-1:0]       link_c0_tx_addr,
    output logic [`SHIM_MDATA_WIDTH-1:0]      link_c0_tx_mdata,
    output logic                              link_c1_tx_wr_valid,
    output logic                              link_c1_tx_intr_valid,
    output shim_pkg::req_type_e               link_c1_tx_req_type,
    output logic [`SHIM_ADDR_WIDTH-1:0]       link_c1_tx_addr,
    output logic [`SHIM_MDATA_WIDTH-1:0]      link_c1_tx_mdata,
    output logic [`SHIM_DATA_WIDTH-1:0]       link_c1_tx_data,
    input  logic                              link_c0_tx_alm_full,
    input  logic                              link_c1_tx_alm_full,

    // Link responses
    input  shim_pkg::rx_hdr_u                 link_c0_rx_hdr,
    input  logic [`SHIM_DATA_WIDTH-1:0]       link_c0_rx_data,
    input  logic                              link_c0_rx_wr_valid,
    input  logic                              link_c0_rx_rd_valid,
    input  logic                              link_c0_rx_cg_valid,
    input  logic                              link_c0_rx_ug_valid,
    input  shim_pkg::rx_hdr_u                 link_c1_rx_hdr,
    input  logic                              link_c1_rx_wr_valid,
    input  logic                              link_c1_rx_intr_valid
);

    shim_pkg::rx_hdr_u            c1_nat_hdr;
    logic                         c1_nat_wr_valid;
    logic                         c1_nat_intr_valid;
    logic                         c0_wr_rsp_valid;
    logic [`SHIM_MDATA_WIDTH-1:0] c0_wr_rsp_mdata;
    logic [`SHIM_MDATA_WIDTH-1:0] wr_rsp_mdata;
    logic                         wr_rsp_not_empty;
    logic                         wr_rsp_deq_en;
    logic                         credit_alm_full;

    // --------------------
    // Request path, upper bits dropped to fit the link
    assign link_c0_tx_rd_valid   = c0_tx_rd_valid;
    assign link_c0_tx_addr       = c0_tx_addr[`SHIM_ADDR_WIDTH-1:0];
    assign link_c0_tx_mdata      = c0_tx_mdata[`SHIM_MDATA_WIDTH-1:0];
    assign link_c1_tx_wr_valid   = c1_tx_wr_valid;
    assign link_c1_tx_intr_valid = c1_tx_intr_valid;
    assign link_c1_tx_req_type   = c1_tx_req_type;
    assign link_c1_tx_addr       = c1_tx_addr[`SHIM_ADDR_WIDTH-1:0];
    assign link_c1_tx_mdata      = c1_tx_mdata[`SHIM_MDATA_WIDTH-1:0];
    assign link_c1_tx_data       = c1_tx_data;

    assign c0_tx_alm_full = link_c0_tx_alm_full;
    assign c1_tx_alm_full = link_c1_tx_alm_full || credit_alm_full;

    // --------------------
    // Response path

    // Write responses only ever leave on channel 1
    assign c0_rx_wr_valid = 1'b0;

    csr_rx_decoder rx_dec
    (
        .clk,
        .reset,
        .link_c0_rx_hdr,
        .link_c0_rx_data,
        .link_c0_rx_wr_valid,
        .link_c0_rx_rd_valid,
        .link_c0_rx_cg_valid,
        .link_c0_rx_ug_valid,
        .link_c1_rx_hdr,
        .link_c1_rx_wr_valid,
        .link_c1_rx_intr_valid,
        .c0_rx_hdr,
        .c0_rx_data,
        .c0_rx_rd_valid,
        .c0_rx_umsg_valid,
        .c0_rx_mmio_wr_valid,
        .c0_rx_mmio_rd_valid,
        .c0_wr_rsp_valid,
        .c0_wr_rsp_mdata,
        .c1_nat_hdr,
        .c1_nat_wr_valid,
        .c1_nat_intr_valid
    );

    wr_rsp_queue wr_q
    (
        .clk,
        .reset,
        .enq_en      (c0_wr_rsp_valid),
        .enq_mdata   (c0_wr_rsp_mdata),
        .deq_en      (wr_rsp_deq_en),
        .first_mdata (wr_rsp_mdata),
        .not_empty   (wr_rsp_not_empty)
    );

    c1_rsp_arbiter c1_arb
    (
        .c1_nat_hdr,
        .c1_nat_wr_valid,
        .c1_nat_intr_valid,
        .queue_not_empty (wr_rsp_not_empty),
        .queue_mdata     (wr_rsp_mdata),
        .deq_en          (wr_rsp_deq_en),
        .c1_rx_hdr,
        .c1_rx_wr_valid,
        .c1_rx_intr_valid
    );

    wr_credit_counter credits
    (
        .clk,
        .reset,
        .c1_tx_wr_valid,
        .c1_tx_req_type,
        .c1_rx_wr_valid,   // After arbitration, so relocated responses count
        .credit_alm_full
    );

endmodule

// ==== design/wr_credit_counter.sv ====
/*
 * Tracks write lines still waiting for a response and raises almost-full
 * early enough that the relocation queue never overflows.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module wr_credit_counter
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 c1_tx_wr_valid,
    input  shim_pkg::req_type_e  c1_tx_req_type,
    input  logic                 c1_rx_wr_valid,
    output logic                 credit_alm_full
);

    localparam int LIMIT = `SHIM_MAX_WRITE_REQS - `SHIM_ALMOST_FULL_THRESHOLD;

    logic [$clog2(`SHIM_MAX_WRITE_REQS):0] num_active;
    logic                                  wr_req;

    // Fences and interrupts get no write response
    assign wr_req = c1_tx_wr_valid &&
                    ((c1_tx_req_type == shim_pkg::req_wrline_i) ||
                     (c1_tx_req_type == shim_pkg::req_wrline_m));

    always_ff @(posedge clk)
    begin
        if (reset)
            num_active <= '0;
        else if (wr_req && !c1_rx_wr_valid)
            num_active <= num_active + 1'b1;
        else if (!wr_req && c1_rx_wr_valid)
            num_active <= num_active - 1'b1;
    end

    assign credit_alm_full = (num_active >= LIMIT);

endmodule

// ==== design/c1_rsp_arbiter.sv ====
/*
 * Fixed priority mux for the channel 1 response port. Native responses
 * win; queued write responses fill the idle cycles.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module c1_rsp_arbiter
(
    input  shim_pkg::rx_hdr_u             c1_nat_hdr,
    input  logic                          c1_nat_wr_valid,
    input  logic                          c1_nat_intr_valid,
    input  logic                          queue_not_empty,
    input  logic [`SHIM_MDATA_WIDTH-1:0]  queue_mdata,
    output logic                          deq_en,
    output shim_pkg::rx_hdr_u             c1_rx_hdr,
    output logic                          c1_rx_wr_valid,
    output logic                          c1_rx_intr_valid
);

    logic nat_busy;

    assign nat_busy = c1_nat_wr_valid || c1_nat_intr_valid;

    always_comb
    begin
        c1_rx_hdr        = c1_nat_hdr;
        c1_rx_wr_valid   = c1_nat_wr_valid;
        c1_rx_intr_valid = c1_nat_intr_valid;
        deq_en           = 1'b0;

        if (!nat_busy && queue_not_empty)
        begin
            // Relocated write response
            c1_rx_hdr              = '0;
            c1_rx_hdr.rsp.rsp_type = shim_pkg::rsp_wrline;
            c1_rx_hdr.rsp.mdata    = queue_mdata;
            c1_rx_wr_valid         = 1'b1;
            deq_en                 = 1'b1;   // Grant pops the head
        end
    end

endmodule

// ==== design/wr_rsp_queue.sv ====
/*
 * Tag FIFO for channel 0 write responses waiting to go out on channel 1.
 * Head is visible on first_mdata while not_empty is high.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module wr_rsp_queue
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enq_en,
    input  logic [`SHIM_MDATA_WIDTH-1:0]  enq_mdata,
    input  logic                          deq_en,
    output logic [`SHIM_MDATA_WIDTH-1:0]  first_mdata,
    output logic                          not_empty
);

    localparam int DEPTH = `SHIM_MAX_WRITE_REQS;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`SHIM_MDATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [PTR_W:0]               count;   // Holds 0 to DEPTH

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_mdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            if (deq_en)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W + 1)'(enq_en) - (PTR_W + 1)'(deq_en);
        end
    end

    assign first_mdata = mem[rd_ptr];
    assign not_empty   = (count != '0);

endmodule

// ==== design/csr_rx_decoder.sv ====
/*
 * Input register for the link receive wires. Turns channel 0 CSR writes
 * into mmio writes or compatibility mmio reads and splits off write responses.
 */
`timescale 1ns/1ps
`include "shim_settings.svh"

module csr_rx_decoder
(
    input  logic                          clk,
    input  logic                          reset,
    input  shim_pkg::rx_hdr_u             link_c0_rx_hdr,
    input  logic [`SHIM_DATA_WIDTH-1:0]   link_c0_rx_data,
    input  logic                          link_c0_rx_wr_valid,
    input  logic                          link_c0_rx_rd_valid,
    input  logic                          link_c0_rx_cg_valid,
    input  logic                          link_c0_rx_ug_valid,
    input  shim_pkg::rx_hdr_u             link_c1_rx_hdr,
    input  logic                          link_c1_rx_wr_valid,
    input  logic                          link_c1_rx_intr_valid,
    output shim_pkg::rx_hdr_u             c0_rx_hdr,
    output logic [`SHIM_DATA_WIDTH-1:0]   c0_rx_data,
    output logic                          c0_rx_rd_valid,
    output logic                          c0_rx_umsg_valid,
    output logic                          c0_rx_mmio_wr_valid,
    output logic                          c0_rx_mmio_rd_valid,
    output logic                          c0_wr_rsp_valid,
    output logic [`SHIM_MDATA_WIDTH-1:0]  c0_wr_rsp_mdata,
    output shim_pkg::rx_hdr_u             c1_nat_hdr,
    output logic                          c1_nat_wr_valid,
    output logic                          c1_nat_intr_valid
);

    logic [31:0]                 csr_wr_high;  // Low word of the last CSR write
    logic                        csr_is_rd;
    shim_pkg::rx_hdr_u           mmio_hdr;
    logic [`SHIM_DATA_WIDTH-1:0] csr_data;

    // --------------------
    // CSR decode

    // The tag field doubles as the CSR address
    assign csr_is_rd = (link_c0_rx_hdr.mmio.address == `SHIM_CSR_READ_COMPAT_ADDR);

    always_comb
    begin
        mmio_hdr = '0;
        mmio_hdr.mmio.length = 2'd1;
        if (csr_is_rd)
        begin
            // Read address sits in the data of the trigger write
            mmio_hdr.mmio.address = link_c0_rx_data[`SHIM_MMIO_ADDR_WIDTH-1:0];
        end
        else
        begin
            mmio_hdr.mmio.address = link_c0_rx_hdr.mmio.address;
        end
    end

    // Link CSRs are 4 bytes, so the high half comes from the write before
    always_comb
    begin
        csr_data = link_c0_rx_data;
        csr_data[63:32] = csr_wr_high;
    end

    // --------------------
    // Input register

    always_ff @(posedge clk)
    begin
        c0_rx_hdr  <= link_c0_rx_cg_valid ? mmio_hdr : link_c0_rx_hdr;
        c0_rx_data <= link_c0_rx_cg_valid ? csr_data : link_c0_rx_data;
        c1_nat_hdr <= link_c1_rx_hdr;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csr_wr_high         <= '0;
            c0_rx_rd_valid      <= 1'b0;
            c0_rx_umsg_valid    <= 1'b0;
            c0_rx_mmio_wr_valid <= 1'b0;
            c0_rx_mmio_rd_valid <= 1'b0;
            c0_wr_rsp_valid     <= 1'b0;
            c1_nat_wr_valid     <= 1'b0;
            c1_nat_intr_valid   <= 1'b0;
        end
        else
        begin
            if (link_c0_rx_cg_valid)
            begin
                csr_wr_high <= link_c0_rx_data[31:0];
            end
            c0_rx_rd_valid      <= link_c0_rx_rd_valid;
            c0_rx_umsg_valid    <= link_c0_rx_ug_valid;
            c0_rx_mmio_wr_valid <= link_c0_rx_cg_valid && !csr_is_rd;
            c0_rx_mmio_rd_valid <= link_c0_rx_cg_valid && csr_is_rd;
            c0_wr_rsp_valid     <= link_c0_rx_wr_valid;   // Diverted to channel 1
            c1_nat_wr_valid     <= link_c1_rx_wr_valid;
            c1_nat_intr_valid   <= link_c1_rx_intr_valid;
        end
    end

    assign c0_wr_rsp_mdata = c0_rx_hdr.rsp.mdata;

endmodule

// ==== design/shim_pkg.sv ====
/*
 * Request and response encodings of the link, and the receive header
 * word that carries either a memory response or an mmio request.
 */
`include "shim_settings.svh"

package shim_pkg;

    // Request kinds on the transmit channels
    typedef enum logic [3:0] {
        req_wrline_i = 4'h1,
        req_wrline_m = 4'h2,
        req_rdline   = 4'h4,
        req_wrfence  = 4'h5,
        req_intr     = 4'h8
    } req_type_e;

    // Response kinds on the receive channels
    typedef enum logic [3:0] {
        rsp_wrline = 4'h1,
        rsp_rdline = 4'h4,
        rsp_intr   = 4'h8,
        rsp_umsg   = 4'hf
    } rsp_type_e;

    // -------------------
    // Receive header views

    typedef struct packed {
        rsp_type_e                                        rsp_type;
        logic [`SHIM_RX_HDR_WIDTH-4-`SHIM_MDATA_WIDTH-1:0] rsvd;
        logic [`SHIM_MDATA_WIDTH-1:0]                     mdata;
    } rsp_hdr_t;

    typedef struct packed {
        logic [`SHIM_RX_HDR_WIDTH-2-`SHIM_MMIO_ADDR_WIDTH-1:0] rsvd;
        logic [1:0]                                            length;   // In 4 byte words
        logic [`SHIM_MMIO_ADDR_WIDTH-1:0]                     address;  // Overlays the tag
    } mmio_hdr_t;

    typedef union packed {
        rsp_hdr_t  rsp;
        mmio_hdr_t mmio;
    } rx_hdr_u;

endpackage

// ==== design/shim_settings.svh ====
/*
 * Width, depth and address constants shared by the legacy link shim.
 * Include before any package or module that sizes its ports from these.
 */
`ifndef SHIM_SETTINGS_SVH
`define SHIM_SETTINGS_SVH

// Link side widths
`define SHIM_DATA_WIDTH       64
`define SHIM_ADDR_WIDTH       32  // Cache line address
`define SHIM_MDATA_WIDTH      14  // Request tag
`define SHIM_MMIO_ADDR_WIDTH  16
`define SHIM_RX_HDR_WIDTH     20  // Receive header word

// Accelerator side widths, wider than the link
`define SHIM_AFU_ADDR_WIDTH   42
`define SHIM_AFU_MDATA_WIDTH  16

// Write relocation
`define SHIM_MAX_WRITE_REQS         16
`define SHIM_ALMOST_FULL_THRESHOLD  4

// A CSR write here is turned into an mmio read
`define SHIM_CSR_READ_COMPAT_ADDR   16'h0ff0

`endif
